// ==== src.f ====
source/ifu_cfg_pkg.sv
source/ifu_types_pkg.sv
source/refill_if.sv
source/fetch_if.sv
source/fetch_fsm.sv
source/beat_counter.sv
source/line_buffer.sv
source/insn_queue.sv
source/ifu_top.sv
dv/clk_gen.sv
dv/ifu_assert.sv
dv/tb_ifu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ifu -f src.f -o sim_ifu

./obj_dir/sim_ifu 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "Test OK" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

// ==== dv/tb_ifu.sv ====
// Fetch unit testbench with an AXI read memory model, random pops and flushes and a PC model
`timescale 1ns/1ps

module tb_ifu;
   import ifu_cfg_pkg::*;

   localparam int NUM_POPS    = 400;
   localparam int CYC_PER_POP = 60;
   localparam int CLK_PERIOD  = 20;          // ns
   localparam logic [31:0] MEM_MULT = 32'h9E37_79B1;
   localparam logic [31:0] MEM_XOR  = 32'h5A5A_0F0F;
   localparam logic [1:0]  RESP_SLVERR = 2'b10;

   logic              clk;
   logic              rst_n;
   logic              ar_ready, ar_valid, r_valid, r_ready;
   logic [ADDR_W-1:0] ar_addr;
   logic [AXI_DW-1:0] r_data;
   logic [1:0]        r_resp;
   logic              flush, id_pop, id_valid, id_exc;
   logic [ADDR_W-1:0] flush_tgt, id_pc;
   logic [INSN_W-1:0] id_ins;

   integer            seed = 94;
   logic              burst_busy;
   logic [ADDR_W-1:0] burst_addr;
   int                burst_beat;
   logic [ADDR_W-1:0] exp_pc;        // PC of the next instruction decode must see
   string             pc_test;
   int                pop_cnt;
   int                hold_cnt;      // Cycles left with pops withheld

   clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

   ifu_top i_ifu_top (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .ar_ready_i  (ar_ready),
      .ar_valid_o  (ar_valid),
      .ar_addr_o   (ar_addr),
      .r_valid_i   (r_valid),
      .r_data_i    (r_data),
      .r_resp_i    (r_resp),
      .r_ready_o   (r_ready),
      .flush_i     (flush),
      .flush_tgt_i (flush_tgt),
      .id_pop_i    (id_pop),
      .id_valid_o  (id_valid),
      .id_ins_o    (id_ins),
      .id_pc_o     (id_pc),
      .id_exc_o    (id_exc)
   );

   function automatic logic [INSN_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
      return (addr * MEM_MULT) ^ MEM_XOR;
   endfunction

   function automatic logic line_faulty(input logic [ADDR_W-1:0] addr);
      return ((addr >> LINE_OFS_W) % 7) == 3;
   endfunction

   task automatic check_value(input string test_name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      if (exp_val !== act_val) begin
         $display("CHECK FAILED %s: expected %h, actual %h at %0t",
                  test_name, exp_val, act_val, $time);
         $display("Test FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // AXI read slave serving one burst at a time with random AR ready and R gaps
   task automatic mem_step();
      logic [ADDR_W-1:0] beat_addr;
      if (ar_valid && ar_ready) begin
         burst_addr = ar_addr;
         burst_beat = 0;
         burst_busy = 1'b1;
      end
      if (r_valid && r_ready) begin
         burst_beat = burst_beat + 1;
         if (burst_beat == LINE_BEATS)
            burst_busy = 1'b0;
      end
      if (!(r_valid && !r_ready)) begin   // An offered beat waits until taken
         if (burst_busy && ($unsigned($random(seed)) % 3) != 0) begin
            beat_addr = burst_addr + ADDR_W'(burst_beat * (AXI_DW / 8));
            r_valid <= 1'b1;
            r_data  <= {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
            r_resp  <= (line_faulty(beat_addr) && burst_beat == 2) ? RESP_SLVERR : RESP_OKAY;
         end else begin
            r_valid <= 1'b0;
         end
      end
      ar_ready <= !burst_busy && (($random(seed) & 1) != 0);
   endtask

   task automatic decode_step();
      if (id_pop && id_valid && !flush) begin
         check_value(pc_test, exp_pc, id_pc);
         check_value("ins_data", mem_word(exp_pc), id_ins);
         check_value("exc_flag", {31'b0, line_faulty(exp_pc)}, {31'b0, id_exc});
         exp_pc   = exp_pc + 32'd4;
         pc_test  = "seq_pc";
         pop_cnt  = pop_cnt + 1;
      end
      if (flush) begin   // Pop in the flush cycle does not count
         exp_pc  = flush_tgt;
         pc_test = "flush_target";
      end

      if (hold_cnt > 0)
         hold_cnt = hold_cnt - 1;
      else if (($unsigned($random(seed)) % 32) == 0)
         hold_cnt = 4 + int'($unsigned($random(seed)) % 16);
      id_pop <= (hold_cnt == 0) && (($unsigned($random(seed)) % 10) < 7);

      if (pop_cnt > 0 && ($unsigned($random(seed)) % 40) == 0) begin
         flush     <= 1'b1;
         flush_tgt <= RESET_PC + ADDR_W'(($unsigned($random(seed)) % 256) * 4);   // 1 KB window
      end else begin
         flush <= 1'b0;
      end
   endtask

   initial begin
      ar_ready   = 1'b0;
      r_valid    = 1'b0;
      r_data     = '0;
      r_resp     = RESP_OKAY;
      flush      = 1'b0;
      flush_tgt  = '0;
      id_pop     = 1'b0;
      burst_busy = 1'b0;
      burst_addr = '0;
      burst_beat = 0;
      exp_pc     = RESET_PC;
      pc_test    = "reset_pc";
      pop_cnt    = 0;
      hold_cnt   = 0;
   end

   always @(posedge clk) begin
      if (rst_n) begin
         mem_step();
         decode_step();
      end
   end

   initial begin
      #(NUM_POPS * CYC_PER_POP * CLK_PERIOD);
      $display("ERROR: timeout with %0d of %0d instructions popped", pop_cnt, NUM_POPS);
      $display("Test FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      wait (pop_cnt >= NUM_POPS);
      $display("Test OK");
      $finish;
   end

endmodule

// ==== dv/ifu_assert.sv ====
// Concurrent checks on the fetch unit AXI read request and decode valid for binding into ifu_top
`timescale 1ns/1ps

module ifu_assert (
   input logic                           clk,
   input logic                           rst_n_i,
   input logic                           ar_valid_i,
   input logic                           ar_ready_i,
   input logic [ifu_cfg_pkg::ADDR_W-1:0] ar_addr_i,
   input logic                           r_valid_i,
   input logic                           r_ready_i,
   input logic                           id_valid_i
);
   import ifu_cfg_pkg::*;

   logic [2:0] beats_seen;   // Saturates at one full line

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i)
         beats_seen <= '0;
      else if (r_valid_i && r_ready_i && beats_seen != 3'(LINE_BEATS))
         beats_seen <= beats_seen + 3'd1;
   end

   // Pending AR keeps valid and address until accepted
   ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
      else $error("AR request changed before ar_ready");

   ar_r_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(ar_valid_i && r_ready_i))
      else $error("ar_valid and r_ready high in the same cycle");

   // No instruction can reach decode before a whole line arrived
   no_early_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
      beats_seen < 3'(LINE_BEATS) |-> !id_valid_i)
      else $error("id_valid high before the first line fill");

endmodule

bind ifu_top ifu_assert i_ifu_assert (
   .clk        (clk),
   .rst_n_i    (rst_n_i),
   .ar_valid_i (ar_valid_o),
   .ar_ready_i (ar_ready_i),
   .ar_addr_i  (ar_addr_o),
   .r_valid_i  (r_valid_i),
   .r_ready_i  (r_ready_o),
   .id_valid_i (id_valid_o)
);

// ==== dv/clk_gen.sv ====
// Testbench clock and reset source giving a 20 ns clock with reset held low for 8 cycles
`timescale 1ns/1ps

module clk_gen (
   output logic clk_o,
   output logic rst_n_o
);
   localparam int HALF_PERIOD  = 10;   // ns
   localparam int RESET_CYCLES = 8;

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;   // Released on a rising edge
   end
endmodule

// ==== source/ifu_top.sv ====
// Instruction fetch unit top level with AXI read master ports and the decode interface
`timescale 1ns/1ps

module ifu_top (
   input  logic                           clk,
   input  logic                           rst_n_i,
   // AXI read address
   input  logic                           ar_ready_i,
   output logic                           ar_valid_o,
   output logic [ifu_cfg_pkg::ADDR_W-1:0] ar_addr_o,
   // AXI read data
   input  logic                           r_valid_i,
   input  logic [ifu_cfg_pkg::AXI_DW-1:0] r_data_i,
   input  logic [1:0]                     r_resp_i,
   output logic                           r_ready_o,
   // Redirect
   input  logic                           flush_i,
   input  logic [ifu_cfg_pkg::ADDR_W-1:0] flush_tgt_i,
   // Decode
   input  logic                           id_pop_i,
   output logic                           id_valid_o,
   output logic [ifu_cfg_pkg::INSN_W-1:0] id_ins_o,
   output logic [ifu_cfg_pkg::ADDR_W-1:0] id_pc_o,
   output logic                           id_exc_o
);

   logic hit;
   logic fill_start;

   refill_if refill_bus ();
   fetch_if  fetch_bus ();

   fetch_fsm i_fetch_fsm (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .flush_i      (flush_i),
      .flush_tgt_i  (flush_tgt_i),
      .hit_i        (hit),
      .ar_ready_i   (ar_ready_i),
      .ar_valid_o   (ar_valid_o),
      .ar_addr_o    (ar_addr_o),
      .r_ready_o    (r_ready_o),
      .fill_start_o (fill_start),
      .refill       (refill_bus.fsm),
      .fetch        (fetch_bus.fsm)
   );

   beat_counter i_beat_counter (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .fill_start_i (fill_start),
      .r_valid_i    (r_valid_i),
      .r_ready_i    (r_ready_o),
      .r_data_i     (r_data_i),
      .r_resp_i     (r_resp_i),
      .refill       (refill_bus.cnt)
   );

   line_buffer i_line_buffer (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .fill_start_i (fill_start),
      .lookup_pc_i  (fetch_bus.pc),   // Same address that selects the word
      .hit_o        (hit),
      .refill       (refill_bus.lbuf),
      .fetch        (fetch_bus.lbuf)
   );

   insn_queue i_insn_queue (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .flush_i      (flush_i),
      .fetch        (fetch_bus.iq),
      .id_pop_i     (id_pop_i),
      .id_valid_o   (id_valid_o),
      .id_ins_o     (id_ins_o),
      .id_pc_o      (id_pc_o),
      .id_exc_o     (id_exc_o)
   );

endmodule

// ==== source/insn_queue.sv ====
// Four-entry instruction FIFO between fetch and decode, emptied on flush
`timescale 1ns/1ps

module insn_queue (
   input  logic                           clk,
   input  logic                           rst_n_i,
   input  logic                           flush_i,
   fetch_if.iq                            fetch,
   input  logic                           id_pop_i,
   output logic                           id_valid_o,
   output logic [ifu_cfg_pkg::INSN_W-1:0] id_ins_o,
   output logic [ifu_cfg_pkg::ADDR_W-1:0] id_pc_o,
   output logic                           id_exc_o
);
   import ifu_cfg_pkg::*;
   import ifu_types_pkg::*;

   fetch_entry_t          iq_mem [IQ_DEPTH];
   fetch_entry_t          head;
   logic [IQ_PTR_W-1:0]   rd_ptr, wr_ptr;
   logic [IQ_CNT_W-1:0]   iq_cnt;
   logic                  do_push, do_pop;

   assign do_push = fetch.push & ~fetch.full;
   assign do_pop  = id_pop_i & id_valid_o;

   always_ff @(posedge clk) begin
      if (do_push)
         iq_mem[wr_ptr] <= '{pc: fetch.pc, ins: fetch.ins, exc: fetch.exc};
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         iq_cnt <= '0;
      end else if (flush_i) begin   // Pop in this cycle is dropped
         rd_ptr <= '0;
         wr_ptr <= '0;
         iq_cnt <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         unique case ({do_push, do_pop})
            2'b10:   iq_cnt <= iq_cnt + 1'b1;
            2'b01:   iq_cnt <= iq_cnt - 1'b1;
            default: ;                       // Both or neither
         endcase
      end
   end

   assign fetch.full = (iq_cnt == IQ_CNT_W'(IQ_DEPTH));

   assign head       = iq_mem[rd_ptr];
   assign id_valid_o = (iq_cnt != '0);
   assign id_ins_o   = head.ins;
   assign id_pc_o    = head.pc;
   assign id_exc_o   = head.exc;

endmodule

// ==== source/line_buffer.sv ====
// Single-line instruction buffer with tag, valid and error state, filled beat by beat
`timescale 1ns/1ps

module line_buffer (
   input  logic                           clk,
   input  logic                           rst_n_i,
   input  logic                           fill_start_i,
   input  logic [ifu_cfg_pkg::ADDR_W-1:0] lookup_pc_i,
   output logic                           hit_o,
   refill_if.lbuf                         refill,
   fetch_if.lbuf                          fetch
);
   import ifu_cfg_pkg::*;

   localparam int WORDS_PER_BEAT = LINE_WORDS / LINE_BEATS;

   logic [INSN_W-1:0]            line_mem [LINE_WORDS];
   logic [ADDR_W-1:LINE_OFS_W]   line_tag;
   logic                         line_valid;
   logic                         line_err;     // Any beat of the line faulted
   logic [WORD_IDX_W-1:0]        rd_idx;

   // Tag on fill start and two words per beat
   always_ff @(posedge clk) begin
      if (fill_start_i)
         line_tag <= lookup_pc_i[ADDR_W-1:LINE_OFS_W];
      if (refill.beat_valid) begin
         for (int w = 0; w < WORDS_PER_BEAT; w++)
            line_mem[refill.beat_idx * WORDS_PER_BEAT + w] <=
               refill.beat_data[w*INSN_W +: INSN_W];
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         line_valid <= 1'b0;
         line_err   <= 1'b0;
      end else if (fill_start_i) begin
         line_valid <= 1'b0;
         line_err   <= 1'b0;
      end else begin
         if (refill.beat_err)
            line_err <= 1'b1;
         if (refill.line_done)
            line_valid <= 1'b1;
      end
   end

   assign hit_o = line_valid & (lookup_pc_i[ADDR_W-1:LINE_OFS_W] == line_tag);

   assign rd_idx    = fetch.pc[LINE_OFS_W-1:LINE_OFS_W-WORD_IDX_W];
   assign fetch.ins = line_mem[rd_idx];
   assign fetch.exc = line_err;

endmodule

// ==== source/beat_counter.sv ====
// Counts accepted R beats of a refill burst and flags the beat index and the line end
`timescale 1ns/1ps

module beat_counter (
   input  logic                           clk,
   input  logic                           rst_n_i,
   input  logic                           fill_start_i,
   input  logic                           r_valid_i,
   input  logic                           r_ready_i,
   input  logic [ifu_cfg_pkg::AXI_DW-1:0] r_data_i,
   input  logic [1:0]                     r_resp_i,
   refill_if.cnt                          refill
);
   import ifu_cfg_pkg::*;

   logic [BEAT_IDX_W-1:0] beat_cnt;
   logic                  beat_acc;

   assign beat_acc = r_valid_i & r_ready_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i)
         beat_cnt <= '0;
      else if (fill_start_i)
         beat_cnt <= '0;                 // New burst
      else if (beat_acc)
         beat_cnt <= beat_cnt + 1'b1;
   end

   assign refill.beat_valid = beat_acc;
   assign refill.beat_data  = r_data_i;
   assign refill.beat_idx   = beat_cnt;
   assign refill.beat_err   = beat_acc & (r_resp_i != RESP_OKAY);
   // Line end taken from the own count instead of r_last
   assign refill.line_done  = beat_acc & (beat_cnt == BEAT_IDX_W'(LINE_BEATS - 1));

endmodule

// ==== source/fetch_fsm.sv ====
// Fetch FSM holding the PC, issuing line refills on AR and pushing hits into the queue
`timescale 1ns/1ps

module fetch_fsm (
   input  logic                           clk,
   input  logic                           rst_n_i,
   input  logic                           flush_i,
   input  logic [ifu_cfg_pkg::ADDR_W-1:0] flush_tgt_i,
   input  logic                           hit_i,
   input  logic                           ar_ready_i,
   output logic                           ar_valid_o,
   output logic [ifu_cfg_pkg::ADDR_W-1:0] ar_addr_o,
   output logic                           r_ready_o,
   output logic                           fill_start_o,
   refill_if.fsm                          refill,
   fetch_if.fsm                           fetch
);
   import ifu_cfg_pkg::*;
   import ifu_types_pkg::*;

   fetch_state_e      state_q, state_nxt;
   logic [ADDR_W-1:0] pc_q, pc_nxt;
   logic              stale_q, stale_nxt;   // Pending AR belongs to a flushed path
   logic              ar_hs;

   assign ar_hs        = ar_valid_o & ar_ready_i;
   assign fill_start_o = ar_hs;
   assign r_ready_o    = (state_q == FILL_DATA) || (state_q == DRAIN);

   // Lookup follows the flush target, so the hit for the new line is known this cycle
   assign fetch.pc   = flush_i ? flush_tgt_i : pc_q;
   assign fetch.push = (state_q == SERVE) & hit_i & ~fetch.full & ~flush_i;

   always_comb begin
      state_nxt = state_q;
      stale_nxt = stale_q;
      pc_nxt    = pc_q;

      if (flush_i)
         pc_nxt = flush_tgt_i;
      else if (fetch.push)
         pc_nxt = pc_q + ADDR_W'(INSN_W / 8);

      unique case (state_q)
         FILL_REQ: begin
            if (ar_hs) begin
               state_nxt = (flush_i || stale_q) ? DRAIN : FILL_DATA;
               stale_nxt = 1'b0;
            end else if (flush_i) begin
               // An issued AR cannot be withdrawn so its burst gets drained later
               if (ar_valid_o)
                  stale_nxt = 1'b1;
               else if (hit_i)
                  state_nxt = SERVE;
            end
         end
         FILL_DATA: begin
            if (refill.line_done)
               state_nxt = flush_i ? FILL_REQ : SERVE;
            else if (flush_i)
               state_nxt = DRAIN;
         end
         DRAIN: begin
            if (refill.line_done)
               state_nxt = FILL_REQ;
         end
         SERVE: begin
            if (flush_i)
               state_nxt = hit_i ? SERVE : FILL_REQ;
            else if (!hit_i)
               state_nxt = FILL_REQ;   // PC left the line
         end
         default: state_nxt = FILL_REQ;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= FILL_REQ;
         stale_q    <= 1'b0;
         pc_q       <= RESET_PC;
         ar_valid_o <= 1'b0;
         ar_addr_o  <= '0;
      end else begin
         state_q <= state_nxt;
         stale_q <= stale_nxt;
         pc_q    <= pc_nxt;
         if (ar_hs) begin
            ar_valid_o <= 1'b0;
         end else if (state_nxt == FILL_REQ && !ar_valid_o) begin
            ar_valid_o <= 1'b1;
            ar_addr_o  <= {pc_nxt[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};   // Line aligned
         end
      end
   end

endmodule

// ==== source/fetch_if.sv ====
// Instruction push path from the fetch FSM and line buffer into the instruction queue
`timescale 1ns/1ps

interface fetch_if;
   import ifu_cfg_pkg::*;

   logic              push;
   logic [ADDR_W-1:0] pc;    // Fetch address, also selects the buffer word
   logic [INSN_W-1:0] ins;
   logic              exc;
   logic              full;

   modport fsm  (output push, pc, input full);
   modport lbuf (input pc, output ins, exc);
   modport iq   (input push, pc, ins, exc, output full);
endinterface

// ==== source/refill_if.sv ====
// Refill beat strobes from the beat counter to the line buffer and the fetch FSM
`timescale 1ns/1ps

interface refill_if;
   import ifu_cfg_pkg::*;

   logic                  beat_valid;   // One cycle per accepted R beat
   logic [AXI_DW-1:0]     beat_data;
   logic [BEAT_IDX_W-1:0] beat_idx;
   logic                  beat_err;     // Response was not OKAY
   logic                  line_done;    // Last beat of the line

   modport cnt  (output beat_valid, beat_data, beat_idx, beat_err, line_done);
   modport lbuf (input beat_valid, beat_data, beat_idx, beat_err, line_done);
   modport fsm  (input line_done);
endinterface

// ==== source/ifu_types_pkg.sv ====
// Fetch unit data types for the FSM state encoding and the instruction queue entry
package ifu_types_pkg;

   // Refill FSM states
   typedef enum logic [1:0] {
      FILL_REQ  = 2'd0,   // AR request pending
      FILL_DATA = 2'd1,   // Collecting beats of a line
      DRAIN     = 2'd2,   // Discarding beats after a flush
      SERVE     = 2'd3    // Pushing instructions from the line
   } fetch_state_e;

   // One queue entry as seen by decode
   typedef struct packed {
      logic [ifu_cfg_pkg::ADDR_W-1:0] pc;
      logic [ifu_cfg_pkg::INSN_W-1:0] ins;
      logic                           exc;   // Bus error on the source line
   } fetch_entry_t;

endpackage

// ==== source/ifu_cfg_pkg.sv ====
// Fetch unit geometry and bus constants that every block of the fetch path imports
package ifu_cfg_pkg;

   // Address and instruction widths
   localparam int ADDR_W = 32;
   localparam int INSN_W = 32;

   // AXI read data path
   localparam int AXI_DW = 64;
   localparam logic [1:0] RESP_OKAY = 2'b00;

   // One burst of four 64-bit beats fills a line of eight words
   localparam int LINE_BEATS = 4;
   localparam int LINE_WORDS = 8;
   localparam int BEAT_IDX_W = 2;
   localparam int WORD_IDX_W = 3;
   localparam int LINE_OFS_W = 5;       // Byte offset within a line

   // Instruction queue
   localparam int IQ_DEPTH = 4;
   localparam int IQ_CNT_W = 3;         // Holds 0..IQ_DEPTH
   localparam int IQ_PTR_W = 2;

   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

endpackage
